// ==== decodeStage.sv ====
`default_nettype none

module decodeStage
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire ifIdT ifId,
	input wire wordT rsData,
	input wire wordT rtData,
	input wire exMemT exMem,
	output regAddrT rs,
	output regAddrT rt,
	output logic stall,
	output logic redirect,
	output wordT target,
	output idExT idEx
);

	opcodeE opcode;
	functE funct;
	ctrlT ctrl;
	regAddrT dest;
	wordT immediate;
	wordT branchTarget;
	wordT jumpTarget;
	logic isBeq;
	logic isBne;
	logic isJump;
	logic taken;
	logic loadUse;
	logic exConflict;
	logic memConflict;
	logic branchHazard;

	assign opcode = opcodeE'(ifId.instruction[31:26]);
	assign funct = functE'(ifId.instruction[5:0]);
	assign rs = ifId.instruction[25:21];
	assign rt = ifId.instruction[20:16];

	//////////////////////////////////////////////////
	// Control decoder
	//////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		dest = rt;
		case (opcode)
			opRtype: begin
				dest = ifId.instruction[15:11];
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt;
					// Unsupported funct, NOP included
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.aluOp = aluOr;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opBeq: isBeq = 1'b1;
			opBne: isBne = 1'b1;
			opJ: isJump = 1'b1;
			opHalt: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

	assign immediate = ctrl.zeroExtend ? {16'b0, ifId.instruction[15:0]}
		: {{16{ifId.instruction[15]}}, ifId.instruction[15:0]};

	//////////////////////////////////////////////////
	// Hazard unit
	//////////////////////////////////////////////////

	// Load in EX feeding this instruction
	assign loadUse = idEx.ctrl.memRead && (idEx.dest != '0)
		&& ((idEx.dest == rs) || (idEx.dest == rt));

	// Branch operands still in flight, WB comes through the register file
	assign exConflict = idEx.ctrl.regWrite && (idEx.dest != '0)
		&& ((idEx.dest == rs) || (idEx.dest == rt));
	assign memConflict = exMem.ctrl.regWrite && (exMem.dest != '0)
		&& ((exMem.dest == rs) || (exMem.dest == rt));
	assign branchHazard = (isBeq || isBne) && (exConflict || memConflict);

	assign stall = loadUse || branchHazard;

	// Branch resolution
	assign taken = (isBeq && (rsData == rtData)) || (isBne && (rsData != rtData));
	assign branchTarget = ifId.pcPlus4 + {immediate[29:0], 2'b00};
	assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instruction[25:0], 2'b00};
	assign target = isJump ? jumpTarget : branchTarget;
	assign redirect = !stall && (taken || isJump);

	// ID/EX register, a stall turns the slot into a bubble
	always_ff @(posedge clk) begin
		idEx.rsData <= rsData;
		idEx.rtData <= rtData;
		idEx.immediate <= immediate;
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.dest <= dest;
		if (reset || stall) begin
			idEx.ctrl <= '0;
		end else begin
			idEx.ctrl <= ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none

module executeStage
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire idExT idEx,
	output exMemT exMem,
	input wire wbT wb
);

	wordT operandA;
	wordT operandB;
	wordT aluB;
	wordT aluResult;

	//////////////////////////////////////////////////
	// Forwarding unit
	//////////////////////////////////////////////////

	// MEM wins over WB, the younger result is the right one
	function automatic wordT forwardOperand(regAddrT src, wordT regValue, exMemT m, wbT w);
		if (m.ctrl.regWrite && (m.dest != '0) && (m.dest == src)) begin
			return m.aluResult;
		end else if (w.regWrite && (w.dest != '0) && (w.dest == src)) begin
			return w.data;
		end
		return regValue;
	endfunction

	assign operandA = forwardOperand(idEx.rs, idEx.rsData, exMem, wb);
	assign operandB = forwardOperand(idEx.rt, idEx.rtData, exMem, wb);

	assign aluB = idEx.ctrl.aluSrc ? idEx.immediate : operandB;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: aluResult = operandA + aluB;
			aluSub: aluResult = operandA - aluB;
			aluAnd: aluResult = operandA & aluB;
			aluOr: aluResult = operandA | aluB;
			aluSlt: aluResult = wordT'($signed(operandA) < $signed(aluB));
			default: aluResult = operandA + aluB;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		exMem.aluResult <= aluResult;
		// Store data is the forwarded rt, never the offset
		exMem.storeData <= operandB;
		exMem.dest <= idEx.dest;
		if (reset) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== instructionFetch.sv ====
`include "mipsPipeline_macros.svh"
`default_nettype none

module instructionFetch
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic imemWrite,
	input wire wordT imemAddr,
	input wire wordT imemData,
	input wire logic stall,
	input wire logic redirect,
	input wire wordT target,
	input wire logic halted,
	output ifIdT ifId
);

	wordT imem [`IMEM_DEPTH];
	wordT pc;
	wordT pcPlus4;
	wordT fetched;
	logic hold;

	// Loader port, only driven while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr[9:2]] <= imemData;
		end
	end

	assign pcPlus4 = pc + 32'd4;
	assign fetched = imem[pc[9:2]];

	// Freeze on a decode stall or once the program has ended
	assign hold = stall || halted;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifId <= '0;
		end else if (!hold) begin
			if (redirect) begin
				pc <= target;
				// Squash the wrong-path fetch into a NOP
				ifId <= '0;
			end else begin
				pc <= pcPlus4;
				ifId.instruction <= fetched;
				ifId.pcPlus4 <= pcPlus4;
			end
		end
	end

endmodule

`default_nettype wire

// ==== memoryStage.sv ====
`include "mipsPipeline_macros.svh"
`default_nettype none

module memoryStage
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire exMemT exMem,
	output wbT wb,
	output logic halted
);

	wordT dmem [`DMEM_DEPTH];
	memWbT memWb;
	logic haltSeen;

	// Word store, nothing past HALT touches memory
	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite && !halted) begin
			dmem[exMem.aluResult[9:2]] <= exMem.storeData;
		end
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		memWb.loadData <= dmem[exMem.aluResult[9:2]];
		memWb.aluResult <= exMem.aluResult;
		memWb.dest <= exMem.dest;
		if (reset) begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
			memWb.halt <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.memToReg <= exMem.ctrl.memToReg;
			memWb.halt <= exMem.ctrl.halt;
		end
	end

	// Sticky once HALT has reached MEM/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			haltSeen <= 1'b0;
		end else if (memWb.halt) begin
			haltSeen <= 1'b1;
		end
	end

	assign halted = haltSeen || memWb.halt;

	// Writeback mux
	assign wb.regWrite = memWb.regWrite && !halted;
	assign wb.dest = memWb.dest;
	assign wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// ==== mipsPipeline.f ====
+incdir+.
mipsPkg.sv
instructionFetch.sv
registerFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsPipeline.sv
mipsPipeline_sva.sv
mipsPipeline_tb.sv

// ==== mipsPipeline.sv ====
`default_nettype none

module mipsPipeline
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Instruction memory loader
	input wire logic imemWrite,
	input wire wordT imemAddr,
	input wire wordT imemData,

	// Register file debug port
	input wire regAddrT debugRegAddr,
	output wordT debugRegData,

	output logic halted
);

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	wbT wb;
	regAddrT rs;
	regAddrT rt;
	wordT rsData;
	wordT rtData;
	logic stall;
	logic redirect;
	wordT target;

	//////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////

	instructionFetch fetch (
		.clk(clk),
		.reset(reset),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.halted(halted),
		.ifId(ifId)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.rs(rs),
		.rt(rt),
		.wb(wb),
		.rsData(rsData),
		.rtData(rtData),
		.debugRegAddr(debugRegAddr),
		.debugRegData(debugRegData)
	);

	decodeStage decode (
		.clk(clk),
		.reset(reset),
		.ifId(ifId),
		.rsData(rsData),
		.rtData(rtData),
		.exMem(exMem),
		.rs(rs),
		.rt(rt),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.idEx(idEx)
	);

	executeStage execute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.exMem(exMem),
		.wb(wb)
	);

	memoryStage memory (
		.clk(clk),
		.reset(reset),
		.exMem(exMem),
		.wb(wb),
		.halted(halted)
	);

endmodule

`default_nettype wire

// ==== mipsPipeline_macros.svh ====
`ifndef MIPS_PIPELINE_MACROS_SVH
`define MIPS_PIPELINE_MACROS_SVH

`default_nettype none

// Datapath word width
`define DATA_WIDTH 32

// Register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Memory depths in words, indexed by address bits 9:2
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`default_nettype wire

`endif

// ==== mipsPipeline_sva.sv ====
`default_nettype none

module mipsPipeline_sva (
	input wire logic clk,
	input wire logic reset,
	input wire logic imemWrite,
	input wire logic stall,
	input wire logic redirect,
	input wire logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far
	int failCount = 0;

	// Once set, halted only clears through reset
	haltedSticky: assert property (@(posedge clk) disable iff (reset) !$fell(halted))
		else begin
			failCount++;
			$error("halted fell while reset was low");
		end

	// First cycle out of reset starts with an empty pipeline
	cleanStart: assert property (@(posedge clk) $fell(reset) |-> (!stall && !redirect))
		else begin
			failCount++;
			$error("stall or redirect high right after reset");
		end

	// Program loading belongs to reset only
	loadInReset: assert property (@(posedge clk) imemWrite |-> reset)
		else begin
			failCount++;
			$error("instruction memory written outside reset");
		end

endmodule

bind mipsPipeline mipsPipeline_sva assertions (
	.clk(clk),
	.reset(reset),
	.imemWrite(imemWrite),
	.stall(stall),
	.redirect(redirect),
	.halted(halted)
);

`default_nettype wire

// ==== mipsPipeline_tb.sv ====
`include "mipsPipeline_macros.svh"
`default_nettype none

module mipsPipeline_tb
	import mipsPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	logic imemWrite;
	wordT imemAddr;
	wordT imemData;
	regAddrT debugRegAddr;
	wordT debugRegData;
	logic halted;

	wordT progWords [`IMEM_DEPTH];
	int progLength;

	mipsPipeline i_dut (
		.clk(clk),
		.reset(reset),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.debugRegAddr(debugRegAddr),
		.debugRegData(debugRegData),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(negedge clk) begin
		if (i_dut.assertions.failCount != 0) begin
			$display("An assertion in the bound checker failed");
			$display("TB FAILED");
			$fatal(1, "assertion failure");
		end
	end

	//////////////////////////////////////////////////
	// Program builder
	//////////////////////////////////////////////////

	function automatic wordT rType(functE fn, regAddrT rd, regAddrT rs, regAddrT rt);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	// Operand order follows assembly with the target register first
	function automatic wordT iType(opcodeE op, regAddrT rt, regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT jType(logic [25:0] index);
		return {opJ, index};
	endfunction

	task automatic clearProgram();
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			progWords[i] = '0;
		end
		progLength = 0;
	endtask

	task automatic appendWord(input wordT w);
		progWords[progLength] = w;
		progLength++;
	endtask

	//////////////////////////////////////////////////
	// Instruction-set model
	//////////////////////////////////////////////////

	// Sequential execution with no branch delay slot
	function automatic void referenceRun(input wordT prog [`IMEM_DEPTH], output wordT regs [32]);
		wordT mem [`DMEM_DEPTH];
		wordT pc;
		wordT instr;
		wordT nextPc;
		wordT a;
		wordT b;
		wordT sext;
		wordT addr;
		wordT value;
		logic [4:0] dest;
		logic write;
		logic done;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && (steps < 5000)) begin
			instr = prog[pc[9:2]];
			nextPc = pc + 32'd4;
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			sext = {{16{instr[15]}}, instr[15:0]};
			addr = a + sext;
			dest = instr[20:16];
			write = 1'b0;
			value = '0;
			case (instr[31:26])
				opRtype: begin
					dest = instr[15:11];
					write = 1'b1;
					case (instr[5:0])
						fnAddu: value = a + b;
						fnSubu: value = a - b;
						fnAnd: value = a & b;
						fnOr: value = a | b;
						fnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: write = 1'b0;
					endcase
				end
				opAddiu: begin
					value = a + sext;
					write = 1'b1;
				end
				opOri: begin
					value = a | {16'b0, instr[15:0]};
					write = 1'b1;
				end
				opLw: begin
					value = mem[addr[9:2]];
					write = 1'b1;
				end
				opSw: mem[addr[9:2]] = b;
				opBeq: begin
					if (a == b) begin
						nextPc = nextPc + {sext[29:0], 2'b00};
					end
				end
				opBne: begin
					if (a != b) begin
						nextPc = nextPc + {sext[29:0], 2'b00};
					end
				end
				opJ: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
				opHalt: done = 1'b1;
				default: ;
			endcase
			if (write && (dest != 5'd0)) begin
				regs[dest] = value;
			end
			pc = nextPc;
			steps++;
		end
	endfunction

	task automatic checkEqual(input string name, input wordT expected, input wordT actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// Load under reset, run to HALT, then compare the whole register file
	task automatic runTest(input string name);
		wordT expected [32];
		wordT actual;
		int cycles;
		referenceRun(progWords, expected);
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < progLength; i++) begin
			@(negedge clk);
			imemWrite = 1'b1;
			imemAddr = wordT'(i * 4);
			imemData = progWords[i];
		end
		@(negedge clk);
		imemWrite = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (!halted && (cycles < 2000)) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Timeout: %s did not reach HALT within 2000 cycles", name);
			$display("TB FAILED");
			$fatal(1, "timeout in %s", name);
		end
		for (int r = 0; r < 32; r++) begin
			@(negedge clk);
			debugRegAddr = regAddrT'(r);
			@(posedge clk);
			actual = debugRegData;
			checkEqual($sformatf("%s r%0d", name, r), expected[r], actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial begin
		int pick;
		regAddrT rd;
		regAddrT ra;
		regAddrT rb;
		logic [15:0] imm;
		reset = 1'b1;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		debugRegAddr = '0;
		void'($urandom(32'h2c7a_816a));

		// Dependent ALU chain forwarded from MEM and WB
		clearProgram();
		appendWord(iType(opAddiu, 1, 0, 16'd5));
		appendWord(iType(opAddiu, 2, 1, 16'hfffd));
		appendWord(iType(opOri, 3, 2, 16'hf0f0));
		appendWord(rType(fnAddu, 4, 3, 1));
		appendWord(rType(fnSubu, 5, 4, 2));
		appendWord(rType(fnAnd, 6, 5, 3));
		appendWord(rType(fnOr, 7, 6, 1));
		appendWord(rType(fnSlt, 8, 5, 7));
		appendWord(iType(opAddiu, 10, 0, 16'hfff9));
		appendWord(rType(fnSlt, 11, 10, 1));
		appendWord(rType(fnSlt, 12, 1, 10));
		appendWord(iType(opHalt, 0, 0, 16'd0));
		runTest("aluChain");

		// Store then load and a load feeding the next instruction
		clearProgram();
		appendWord(iType(opAddiu, 1, 0, 16'h0040));
		appendWord(iType(opAddiu, 2, 0, 16'd1234));
		appendWord(iType(opSw, 2, 1, 16'd0));
		appendWord(iType(opLw, 3, 1, 16'd0));
		appendWord(rType(fnAddu, 4, 3, 2));
		appendWord(iType(opSw, 4, 1, 16'd4));
		appendWord(iType(opLw, 5, 1, 16'd4));
		appendWord(rType(fnAddu, 6, 5, 5));
		appendWord(iType(opHalt, 0, 0, 16'd0));
		runTest("loadStore");

		// Markers r20, r21 and r25 sit on wrong paths
		clearProgram();
		appendWord(iType(opAddiu, 1, 0, 16'd3));
		appendWord(iType(opAddiu, 2, 0, 16'd3));
		appendWord(iType(opBeq, 2, 1, 16'd1));
		appendWord(iType(opAddiu, 20, 0, 16'd1));
		appendWord(iType(opBne, 2, 1, 16'd1));
		appendWord(iType(opAddiu, 3, 0, 16'd7));
		appendWord(iType(opAddiu, 4, 3, 16'd1));
		appendWord(iType(opBne, 3, 4, 16'd1));
		appendWord(iType(opAddiu, 21, 0, 16'd1));
		appendWord(iType(opBeq, 3, 4, 16'd1));
		appendWord(iType(opAddiu, 5, 0, 16'd9));
		appendWord(iType(opAddiu, 6, 0, 16'h0080));
		appendWord(iType(opSw, 3, 6, 16'd0));
		appendWord(iType(opLw, 7, 6, 16'd0));
		appendWord(iType(opBeq, 3, 7, 16'd1));
		appendWord(iType(opAddiu, 25, 0, 16'd1));
		appendWord(iType(opHalt, 0, 0, 16'd0));
		runTest("branches");

		// Jump over a block of writes
		clearProgram();
		appendWord(iType(opAddiu, 1, 0, 16'd1));
		appendWord(jType(26'd5));
		appendWord(iType(opAddiu, 22, 0, 16'd1));
		appendWord(iType(opAddiu, 23, 0, 16'd1));
		appendWord(iType(opAddiu, 24, 0, 16'd1));
		appendWord(iType(opAddiu, 2, 1, 16'd1));
		appendWord(iType(opHalt, 0, 0, 16'd0));
		runTest("jump");

		// r0 stays zero and code after HALT has no effect
		clearProgram();
		appendWord(iType(opAddiu, 0, 0, 16'd5));
		appendWord(iType(opAddiu, 1, 0, 16'd9));
		appendWord(rType(fnAddu, 0, 1, 1));
		appendWord(rType(fnAddu, 2, 0, 0));
		appendWord(iType(opHalt, 0, 0, 16'd0));
		appendWord(iType(opAddiu, 3, 0, 16'd1));
		appendWord(iType(opAddiu, 4, 1, 16'd1));
		appendWord(rType(fnAddu, 1, 1, 1));
		runTest("zeroAndHalt");

		// Random ALU and immediate mix
		clearProgram();
		for (int k = 0; k < 40; k++) begin
			pick = int'($urandom % 7);
			rd = regAddrT'($urandom);
			ra = regAddrT'($urandom);
			rb = regAddrT'($urandom);
			imm = 16'($urandom);
			case (pick)
				0: appendWord(rType(fnAddu, rd, ra, rb));
				1: appendWord(rType(fnSubu, rd, ra, rb));
				2: appendWord(rType(fnAnd, rd, ra, rb));
				3: appendWord(rType(fnOr, rd, ra, rb));
				4: appendWord(rType(fnSlt, rd, ra, rb));
				5: appendWord(iType(opAddiu, rd, ra, imm));
				default: appendWord(iType(opOri, rd, ra, imm));
			endcase
		end
		appendWord(iType(opHalt, 0, 0, 16'd0));
		runTest("random");

		// One more falling edge for the assertion monitor
		@(negedge clk);
		#1;
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`include "mipsPipeline_macros.svh"
`default_nettype none

package mipsPkg;

	typedef logic [`DATA_WIDTH-1:0] wordT;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	//////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLw    = 6'h23,
		opSw    = 6'h2b,
		opHalt  = 6'h3f
	} opcodeE;

	// R-type funct field
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpE;

	//////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////

	// All zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		logic zeroExtend;
		logic halt;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		wordT instruction;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rsData;
		wordT rtData;
		wordT immediate;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluResult;
		wordT storeData;
		regAddrT dest;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic halt;
		wordT loadData;
		wordT aluResult;
		regAddrT dest;
	} memWbT;

	// Writeback bus, shared by the register file and forwarding
	typedef struct packed {
		logic regWrite;
		regAddrT dest;
		wordT data;
	} wbT;

endpackage

`default_nettype wire

// ==== registerFile.sv ====
`include "mipsPipeline_macros.svh"
`default_nettype none

module registerFile
	import mipsPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire regAddrT rs,
	input wire regAddrT rt,
	input wire wbT wb,
	output wordT rsData,
	output wordT rtData,
	input wire regAddrT debugRegAddr,
	output wordT debugRegData
);

	wordT regs [`REG_COUNT];

	// Register 0 is hardwired, a same-cycle write is passed straight through
	function automatic wordT bypassRead(regAddrT addr, wordT stored, wbT w);
		if (addr == '0) begin
			return '0;
		end else if (w.regWrite && (w.dest == addr)) begin
			return w.data;
		end
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regWrite && (wb.dest != '0)) begin
			regs[wb.dest] <= wb.data;
		end
	end

	assign rsData = bypassRead(rs, regs[rs], wb);
	assign rtData = bypassRead(rt, regs[rt], wb);

	// Debug view of the stored state
	assign debugRegData = regs[debugRegAddr];

endmodule

`default_nettype wire
